/* design/csr_bridge.sv */
// Bridge turning one Wishbone access into one two-cycle CSR bus cycle
`timescale 1ns/1ns
`default_nettype none

module csr_bridge import soc_pkg::*; (
	input wire logic sys_clk,
	input wire logic sys_rst_i,
	wb_if.slave bus,
	csr_if.bridge csr
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_XFER,
		ST_DONE
	} state_t;

	state_t state;

	// CSR space has no error response
	assign bus.err = 1'b0;

	// ----------------------------------------
	// Access sequencer
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			state <= ST_IDLE;
			csr.we <= 1'b0;
			bus.ack <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					bus.ack <= 1'b0;
					if (bus.cyc && bus.stb) begin
						// Cycle 1 presents address and write strobe
						csr.we <= bus.we;
						state <= ST_XFER;
					end
				end
				ST_XFER: begin
					// Strobe dropped so the write lands once
					csr.we <= 1'b0;
					bus.ack <= 1'b1;
					state <= ST_DONE;
				end
				default: begin
					// Master releases stb after seeing ack
					bus.ack <= 1'b0;
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Payload registers
	always_ff @(posedge sys_clk) begin
		if (state == ST_IDLE) begin
			csr.adr <= bus.adr[CSR_ADR_LSB +: CSR_ADR_W];
			csr.dat_w <= bus.dat_w;
		end
		// Cycle 2 captures read data with the ack
		if (state == ST_XFER) begin
			bus.dat_r <= csr.dat_r;
		end
	end

endmodule

`default_nettype wire

/* design/monitor_ram.sv */
// Byte-writable monitor memory whose lower half can be write-locked for debug
`timescale 1ns/1ns
`default_nettype none

module monitor_ram import soc_pkg::*; (
	input wire logic sys_clk,
	input wire logic sys_rst_i,
	input wire logic write_lock_i,
	wb_if.slave bus
);

	logic [WB_DAT_W-1:0] mem [MON_WORDS];
	logic [MON_ADR_W-1:0] word_adr;
	logic access;
	logic locked;

	assign word_adr = bus.adr[2 +: MON_ADR_W];
	// New access only while no ack is out
	assign access = bus.cyc && bus.stb && !bus.ack;
	// Top word-address bit clear means lower half
	assign locked = write_lock_i && !word_adr[MON_ADR_W-1];

	// Memory never signals an error
	assign bus.err = 1'b0;

	// ----------------------------------------
	// Storage
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (access && bus.we && !locked) begin
			for (int i = 0; i < WB_SEL_W; i++) begin
				if (bus.sel[i]) begin
					mem[word_adr][8*i +: 8] <= bus.dat_w[8*i +: 8];
				end
			end
		end
		// Read data lines up with the ack
		bus.dat_r <= mem[word_adr];
	end

	// Ack one cycle after stb
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			bus.ack <= 1'b0;
		end else begin
			// Locked writes still acked
			bus.ack <= access;
		end
	end

endmodule

`default_nettype wire

/* design/reset_gen.sv */
// Reset stretcher turning a pin or software request into a long system reset
`timescale 1ns/1ns
`default_nettype none

module reset_gen import soc_pkg::*; (
	input wire logic sys_clk,
	input wire logic trigger_reset,
	input wire logic hard_reset_i,
	output logic sys_rst_o
);

	// Counter starts loaded so reset is active from power-up
	logic [RST_CNT_W-1:0] rst_cnt = RST_CNT_W'(RST_STRETCH);
	logic sys_rst_q = 1'b1;

	always_ff @(posedge sys_clk) begin
		// Any request restarts the full stretch
		if (trigger_reset || hard_reset_i) begin
			rst_cnt <= RST_CNT_W'(RST_STRETCH);
		end else if (rst_cnt != '0) begin
			rst_cnt <= rst_cnt - 1'b1;
		end
		// Registered so the reset edge is clean
		sys_rst_q <= (rst_cnt != '0);
	end

	assign sys_rst_o = sys_rst_q;

endmodule

`default_nettype wire

/* design/soc_ifs.sv */
// Wishbone and CSR bus interfaces used between the blocks of the SoC core
`timescale 1ns/1ns
`default_nettype none

// ----------------------------------------
// Wishbone classic link
// ----------------------------------------
interface wb_if import soc_pkg::*; ();

	logic [WB_ADR_W-1:0] adr;
	logic [WB_DAT_W-1:0] dat_w;
	logic [WB_DAT_W-1:0] dat_r;
	logic [WB_SEL_W-1:0] sel;
	logic we;
	logic cyc;
	logic stb;
	// Single-cycle handshake back to the master
	logic ack;
	logic err;

	modport master (
		output adr, dat_w, sel, we, cyc, stb,
		input dat_r, ack, err
	);

	modport slave (
		input adr, dat_w, sel, we, cyc, stb,
		output dat_r, ack, err
	);

endinterface

// ----------------------------------------
// CSR bus
// ----------------------------------------
interface csr_if import soc_pkg::*; ();

	// Word address with page in the top bits
	logic [CSR_ADR_W-1:0] adr;
	logic we;
	logic [WB_DAT_W-1:0] dat_w;
	logic [WB_DAT_W-1:0] dat_r;

	modport bridge (
		output adr, we, dat_w,
		input dat_r
	);

	modport peripheral (
		input adr, we, dat_w,
		output dat_r
	);

endinterface

`default_nettype wire

/* design/soc_pkg.sv */
// Shared address map, CSR register map, widths and reset constants for the SoC core
`default_nettype none

package soc_pkg;

	// ----------------------------------------
	// Wishbone bus
	// ----------------------------------------
	localparam int WB_ADR_W = 32;
	localparam int WB_DAT_W = 32;
	localparam int WB_SEL_W = 4;

	// Slot field of the address, bit 31 left out so the upper half shadows the lower
	localparam int SLOT_MSB = 30;
	localparam int SLOT_LSB = 28;
	localparam int SLOT_W = SLOT_MSB - SLOT_LSB + 1;
	localparam logic [SLOT_W-1:0] SLOT_NULL = 3'd0;
	localparam logic [SLOT_W-1:0] SLOT_MONITOR = 3'd1;
	localparam logic [SLOT_W-1:0] SLOT_CSR = 3'd6;

	// Monitor memory
	localparam int MON_WORDS = 512;
	localparam int MON_ADR_W = 9;

	// ----------------------------------------
	// CSR bus
	// ----------------------------------------
	localparam int CSR_ADR_W = 14;
	// Word address starts at bus bit 2
	localparam int CSR_ADR_LSB = 2;
	localparam int CSR_PAGE_W = 4;
	localparam logic [CSR_PAGE_W-1:0] SYSCTL_PAGE = 4'd1;

	// System controller registers
	localparam int REG_IDX_W = 3;
	localparam logic [REG_IDX_W-1:0] REG_GPIO_IN = 3'd0;
	localparam logic [REG_IDX_W-1:0] REG_GPIO_OUT = 3'd1;
	localparam logic [REG_IDX_W-1:0] REG_GPIO_MASK = 3'd2;
	localparam logic [REG_IDX_W-1:0] REG_TIMER_CTRL = 3'd3;
	localparam logic [REG_IDX_W-1:0] REG_TIMER_CMP = 3'd4;
	localparam logic [REG_IDX_W-1:0] REG_TIMER_CNT = 3'd5;
	localparam logic [REG_IDX_W-1:0] REG_SYS_CTRL = 3'd6;
	localparam logic [REG_IDX_W-1:0] REG_SYSTEM_ID = 3'd7;

	// Control bit positions
	localparam int TCTL_EN = 0;
	localparam int TCTL_AR = 1;
	localparam int SCTL_LOCK = 0;
	localparam int SCTL_BUSERR = 1;
	localparam int SCTL_HRST = 2;

	// GPIO and board identity
	localparam int GPIO_IN_W = 4;
	localparam int GPIO_OUT_W = 2;
	localparam logic [3:0] PCB_REVISION = 4'b0010;
	localparam logic [WB_DAT_W-1:0] SYSTEM_ID = 32'h5c01_0100;

	// Reset stretch length in cycles
	localparam int RST_STRETCH = 255;
	localparam int RST_CNT_W = $clog2(RST_STRETCH + 1);

endpackage

`default_nettype wire

/* design/soc_top.sv */
// Top level of the SoC control core joining reset, switch, RAM, bridge and controller
`timescale 1ns/1ns
`default_nettype none

module soc_top import soc_pkg::*; (
	input wire logic sys_clk,
	input wire logic trigger_reset,
	input wire logic [WB_ADR_W-1:0] wb_adr_i,
	input wire logic [WB_DAT_W-1:0] wb_dat_i,
	input wire logic [WB_SEL_W-1:0] wb_sel_i,
	input wire logic wb_we_i,
	input wire logic wb_cyc_i,
	input wire logic wb_stb_i,
	input wire logic [GPIO_IN_W-1:0] gpio_in_i,
	output logic [WB_DAT_W-1:0] wb_dat_o,
	output logic wb_ack_o,
	output logic wb_err_o,
	output logic [GPIO_OUT_W-1:0] led_o,
	output logic gpio_irq_o,
	output logic timer_irq_o
);

	logic sys_rst;
	logic hard_reset;
	logic debug_write_lock;
	logic bus_errors_en;

	// Slave links and CSR bus
	wb_if mon_bus ();
	wb_if csr_bus ();
	csr_if csr ();

	// ----------------------------------------
	// Reset and bus fabric
	// ----------------------------------------
	reset_gen i_reset_gen (
		.sys_clk (sys_clk),
		.trigger_reset (trigger_reset),
		.hard_reset_i (hard_reset),
		.sys_rst_o (sys_rst)
	);

	wb_switch i_wb_switch (
		.sys_clk (sys_clk),
		.sys_rst_i (sys_rst),
		.wb_adr_i (wb_adr_i),
		.wb_dat_i (wb_dat_i),
		.wb_sel_i (wb_sel_i),
		.wb_we_i (wb_we_i),
		.wb_cyc_i (wb_cyc_i),
		.wb_stb_i (wb_stb_i),
		.bus_errors_en_i (bus_errors_en),
		.wb_dat_o (wb_dat_o),
		.wb_ack_o (wb_ack_o),
		.wb_err_o (wb_err_o),
		.mon_bus (mon_bus),
		.csr_bus (csr_bus)
	);

	// ----------------------------------------
	// Slaves
	// ----------------------------------------
	monitor_ram i_monitor_ram (
		.sys_clk (sys_clk),
		.sys_rst_i (sys_rst),
		.write_lock_i (debug_write_lock),
		.bus (mon_bus)
	);

	csr_bridge i_csr_bridge (
		.sys_clk (sys_clk),
		.sys_rst_i (sys_rst),
		.bus (csr_bus),
		.csr (csr)
	);

	// Only CSR peripheral on page 1
	sys_ctl i_sys_ctl (
		.sys_clk (sys_clk),
		.sys_rst_i (sys_rst),
		.gpio_in_i (gpio_in_i),
		.csr (csr),
		.gpio_out_o (led_o),
		.gpio_irq_o (gpio_irq_o),
		.timer_irq_o (timer_irq_o),
		.debug_write_lock_o (debug_write_lock),
		.bus_errors_en_o (bus_errors_en),
		.hard_reset_o (hard_reset)
	);

endmodule

`default_nettype wire

/* design/sys_ctl.sv */
// System controller with GPIO, compare timer, interrupts, control bits and system ID
`timescale 1ns/1ns
`default_nettype none

module sys_ctl import soc_pkg::*; (
	input wire logic sys_clk,
	input wire logic sys_rst_i,
	input wire logic [GPIO_IN_W-1:0] gpio_in_i,
	csr_if.peripheral csr,
	output logic [GPIO_OUT_W-1:0] gpio_out_o,
	output logic gpio_irq_o,
	output logic timer_irq_o,
	output logic debug_write_lock_o,
	output logic bus_errors_en_o,
	output logic hard_reset_o
);

	logic page_hit;
	logic csr_wr;
	logic [REG_IDX_W-1:0] reg_idx;
	logic [GPIO_IN_W-1:0] gpio_meta;
	logic [GPIO_IN_W-1:0] gpio_in_q;
	logic [GPIO_IN_W-1:0] gpio_prev;
	logic [GPIO_IN_W-1:0] gpio_mask;
	logic timer_en;
	logic timer_ar;
	logic timer_hit;
	logic [WB_DAT_W-1:0] timer_cmp;
	logic [WB_DAT_W-1:0] timer_cnt;

	// Page from the top CSR address bits
	assign page_hit = (csr.adr[CSR_ADR_W-1 -: CSR_PAGE_W] == SYSCTL_PAGE);
	assign reg_idx = csr.adr[REG_IDX_W-1:0];
	assign csr_wr = csr.we && page_hit;

	// ----------------------------------------
	// GPIO input sync and change detect
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		gpio_meta <= gpio_in_i;
		gpio_in_q <= gpio_meta;
		gpio_prev <= gpio_in_q;
	end

	// Timer match while running
	assign timer_hit = timer_en && (timer_cnt == timer_cmp);
	assign timer_irq_o = timer_hit;

	// ----------------------------------------
	// Registers and timer
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			gpio_out_o <= '0;
			gpio_mask <= '0;
			gpio_irq_o <= 1'b0;
			timer_en <= 1'b0;
			timer_ar <= 1'b0;
			timer_cmp <= '0;
			timer_cnt <= '0;
			debug_write_lock_o <= 1'b0;
			bus_errors_en_o <= 1'b0;
			hard_reset_o <= 1'b0;
		end else begin
			// Pulse on any masked input edge
			gpio_irq_o <= |((gpio_in_q ^ gpio_prev) & gpio_mask);
			hard_reset_o <= 1'b0;
			// Count clears on match and stops unless auto-reload
			if (timer_hit) begin
				timer_cnt <= '0;
				timer_en <= timer_ar;
			end else if (timer_en) begin
				timer_cnt <= timer_cnt + 32'd1;
			end
			// CSR writes win over timer updates
			if (csr_wr) begin
				case (reg_idx)
					REG_GPIO_OUT: gpio_out_o <= csr.dat_w[GPIO_OUT_W-1:0];
					REG_GPIO_MASK: gpio_mask <= csr.dat_w[GPIO_IN_W-1:0];
					REG_TIMER_CTRL: begin
						timer_en <= csr.dat_w[TCTL_EN];
						timer_ar <= csr.dat_w[TCTL_AR];
					end
					REG_TIMER_CMP: timer_cmp <= csr.dat_w;
					REG_TIMER_CNT: timer_cnt <= csr.dat_w;
					REG_SYS_CTRL: begin
						debug_write_lock_o <= csr.dat_w[SCTL_LOCK];
						bus_errors_en_o <= csr.dat_w[SCTL_BUSERR];
						// Write-only bit gives a single pulse
						hard_reset_o <= csr.dat_w[SCTL_HRST];
					end
					default: ;
				endcase
			end
		end
	end

	// ----------------------------------------
	// Read mux
	// ----------------------------------------
	always_comb begin
		csr.dat_r = '0;
		// Other pages read zero
		if (page_hit) begin
			case (reg_idx)
				REG_GPIO_IN: csr.dat_r = {{(WB_DAT_W - $bits(PCB_REVISION) - GPIO_IN_W){1'b0}},
					PCB_REVISION, gpio_in_q};
				REG_GPIO_OUT: csr.dat_r = {{(WB_DAT_W - GPIO_OUT_W){1'b0}}, gpio_out_o};
				REG_GPIO_MASK: csr.dat_r = {{(WB_DAT_W - GPIO_IN_W){1'b0}}, gpio_mask};
				REG_TIMER_CTRL: csr.dat_r = {{(WB_DAT_W - 2){1'b0}}, timer_ar, timer_en};
				REG_TIMER_CMP: csr.dat_r = timer_cmp;
				REG_TIMER_CNT: csr.dat_r = timer_cnt;
				// Hard reset bit reads back zero
				REG_SYS_CTRL: csr.dat_r = {{(WB_DAT_W - 3){1'b0}}, 1'b0, bus_errors_en_o,
					debug_write_lock_o};
				default: csr.dat_r = SYSTEM_ID;
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/wb_switch.sv */
// Address switch steering bus requests to the slaves and trapping the null region
`timescale 1ns/1ns
`default_nettype none

module wb_switch import soc_pkg::*; (
	input wire logic sys_clk,
	input wire logic sys_rst_i,
	input wire logic [WB_ADR_W-1:0] wb_adr_i,
	input wire logic [WB_DAT_W-1:0] wb_dat_i,
	input wire logic [WB_SEL_W-1:0] wb_sel_i,
	input wire logic wb_we_i,
	input wire logic wb_cyc_i,
	input wire logic wb_stb_i,
	input wire logic bus_errors_en_i,
	output logic [WB_DAT_W-1:0] wb_dat_o,
	output logic wb_ack_o,
	output logic wb_err_o,
	wb_if.master mon_bus,
	wb_if.master csr_bus
);

	logic [SLOT_W-1:0] slot;
	logic mon_hit;
	logic csr_hit;
	logic null_hit;
	logic bus_req;
	logic null_ack;
	logic null_err;

	// ----------------------------------------
	// Slot decode
	// ----------------------------------------
	// Bit 31 not decoded
	assign slot = wb_adr_i[SLOT_MSB:SLOT_LSB];
	assign mon_hit = (slot == SLOT_MONITOR);
	assign csr_hit = (slot == SLOT_CSR);
	// Null slot and every unmapped slot answered here
	assign null_hit = !mon_hit && !csr_hit;
	assign bus_req = wb_cyc_i && wb_stb_i;

	// Shared request lines
	assign mon_bus.adr = wb_adr_i;
	assign mon_bus.dat_w = wb_dat_i;
	assign mon_bus.sel = wb_sel_i;
	assign mon_bus.we = wb_we_i;
	assign mon_bus.cyc = wb_cyc_i;
	assign csr_bus.adr = wb_adr_i;
	assign csr_bus.dat_w = wb_dat_i;
	assign csr_bus.sel = wb_sel_i;
	assign csr_bus.we = wb_we_i;
	assign csr_bus.cyc = wb_cyc_i;

	// Strobe only to the chosen slave
	assign mon_bus.stb = wb_stb_i && mon_hit;
	assign csr_bus.stb = wb_stb_i && csr_hit;

	// ----------------------------------------
	// Null region responder
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			null_ack <= 1'b0;
			null_err <= 1'b0;
		end else begin
			// One-cycle ack and no repeat while stb is still held
			null_ack <= bus_req && null_hit && !null_ack;
			// Null pointer trap only on slot 0
			null_err <= bus_req && null_hit && !null_ack && bus_errors_en_i
				&& (slot == SLOT_NULL);
		end
	end

	// Return path from the addressed slave
	always_comb begin
		case (slot)
			SLOT_MONITOR: begin
				wb_dat_o = mon_bus.dat_r;
				wb_ack_o = mon_bus.ack;
				wb_err_o = mon_bus.err;
			end
			SLOT_CSR: begin
				wb_dat_o = csr_bus.dat_r;
				wb_ack_o = csr_bus.ack;
				wb_err_o = csr_bus.err;
			end
			default: begin
				// Unmapped space reads zero
				wb_dat_o = '0;
				wb_ack_o = null_ack;
				wb_err_o = null_err;
			end
		endcase
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the SoC core testbench with Verilator; the log decides pass or fail

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

rm -f "$SIM_LOG" \
	&& verilator --binary --timing --assert -f soc_top.f --top-module soc_top_tb \
		--Mdir "$BUILD_DIR" -o soc_top_sim > "$BUILD_LOG" 2>&1 \
	|| { cat "$BUILD_LOG"; echo "Build failed"; exit 1; }

"./$BUILD_DIR/soc_top_sim" > "$SIM_LOG" 2>&1
cat "$SIM_LOG"

grep -qx "PASS: all tests" "$SIM_LOG" && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

/* soc_top.f */
design/soc_pkg.sv
design/soc_ifs.sv
design/reset_gen.sv
design/wb_switch.sv
design/monitor_ram.sv
design/csr_bridge.sv
design/sys_ctl.sv
design/soc_top.sv
test/soc_top_asserts.sv
test/soc_top_tb.sv

/* test/soc_top_asserts.sv */
// Handshake assertions for the address switch and the CSR bridge bus links
`timescale 1ns/1ns
`default_nettype none

module soc_top_asserts (
	input wire logic sys_clk,
	input wire logic sys_rst_i,
	input wire logic cyc_i,
	input wire logic stb_i,
	input wire logic ack_i,
	input wire logic err_i
);

	// ----------------------------------------
	// Wishbone classic rules
	// ----------------------------------------
	// Ack is a single-cycle pulse
	ack_single: assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		ack_i |=> !ack_i)
		else $error("ack stayed high for two cycles");

	// Error only as part of an ack
	err_with_ack: assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		err_i |-> ack_i)
		else $error("err raised without ack");

	// Master still requesting when ack arrives
	ack_needs_req: assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		ack_i |-> (cyc_i && stb_i))
		else $error("ack without cyc and stb");

endmodule

// Top-level side of the switch
bind wb_switch soc_top_asserts i_switch_asserts (
	.sys_clk (sys_clk),
	.sys_rst_i (sys_rst_i),
	.cyc_i (wb_cyc_i),
	.stb_i (wb_stb_i),
	.ack_i (wb_ack_o),
	.err_i (wb_err_o)
);

bind csr_bridge soc_top_asserts i_bridge_asserts (
	.sys_clk (sys_clk),
	.sys_rst_i (sys_rst_i),
	.cyc_i (bus.cyc),
	.stb_i (bus.stb),
	.ack_i (bus.ack),
	.err_i (bus.err)
);

`default_nettype wire

/* test/soc_top_tb.sv */
// Table-driven testbench for the SoC control core
`timescale 1ns/1ns
`default_nettype none

module soc_top_tb import soc_pkg::*; ();

	// One table row per bus access
	typedef struct {
		string name;
		bit we;
		logic [WB_ADR_W-1:0] adr;
		logic [WB_SEL_W-1:0] sel;
		logic [WB_DAT_W-1:0] dat;
		logic [WB_DAT_W-1:0] exp;
		bit exp_err;
	} step_t;

	localparam int ACCESS_LIMIT = 20;
	localparam int TIMER_N = 20;
	// Accesses and windows outside the table
	localparam int EXTRA_CYCLES = 600;
	localparam logic [GPIO_IN_W-1:0] GPIO_PATTERN = 4'b1010;
	localparam logic [GPIO_OUT_W-1:0] LED_PATTERN = 2'b10;

	logic sys_clk = 1'b0;
	logic trigger_reset;
	logic [WB_ADR_W-1:0] wb_adr_i;
	logic [WB_DAT_W-1:0] wb_dat_i;
	logic [WB_SEL_W-1:0] wb_sel_i;
	logic wb_we_i;
	logic wb_cyc_i;
	logic wb_stb_i;
	logic [GPIO_IN_W-1:0] gpio_in_i;
	logic [WB_DAT_W-1:0] wb_dat_o;
	logic wb_ack_o;
	logic wb_err_o;
	logic [GPIO_OUT_W-1:0] led_o;
	logic gpio_irq_o;
	logic timer_irq_o;

	step_t steps[$];
	// Reference copy of RAM contents
	logic [WB_DAT_W-1:0] ram_ref [MON_WORDS];
	logic [31:0] lfsr_state = 32'hdc56_4a8a;
	bit table_ready = 1'b0;
	int gpio_pulses = 0;
	int timer_pulses = 0;

	// 4 ns clock
	always #2 sys_clk = ~sys_clk;

	soc_top i_dut (
		.sys_clk (sys_clk),
		.trigger_reset (trigger_reset),
		.wb_adr_i (wb_adr_i),
		.wb_dat_i (wb_dat_i),
		.wb_sel_i (wb_sel_i),
		.wb_we_i (wb_we_i),
		.wb_cyc_i (wb_cyc_i),
		.wb_stb_i (wb_stb_i),
		.gpio_in_i (gpio_in_i),
		.wb_dat_o (wb_dat_o),
		.wb_ack_o (wb_ack_o),
		.wb_err_o (wb_err_o),
		.led_o (led_o),
		.gpio_irq_o (gpio_irq_o),
		.timer_irq_o (timer_irq_o)
	);

	// ----------------------------------------
	// Helpers
	// ----------------------------------------
	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	// Selected bytes replaced and others kept
	function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
		input logic [31:0] new_w, input logic [WB_SEL_W-1:0] sel);
		logic [31:0] r;
		r = old_w;
		for (int b = 0; b < WB_SEL_W; b++) begin
			if (sel[b]) begin
				r[8*b +: 8] = new_w[8*b +: 8];
			end
		end
		return r;
	endfunction

	// Bit 31 set gives the shadow alias
	function automatic logic [31:0] mon_adr(input int word, input bit shadow);
		return {shadow, SLOT_MONITOR, 28'(word * 4)};
	endfunction

	// Page in bus bits 15:12 and register in bits 4:2
	function automatic logic [31:0] csr_adr(input logic [3:0] page, input logic [2:0] idx);
		return {1'b0, SLOT_CSR, 12'h000, page, 7'h00, idx, 2'b00};
	endfunction

	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic add_step(input string name, input bit we, input logic [31:0] adr,
		input logic [3:0] sel, input logic [31:0] dat, input logic [31:0] exp,
		input bit exp_err);
		step_t s;
		s.name = name;
		s.we = we;
		s.adr = adr;
		s.sel = sel;
		s.dat = dat;
		s.exp = exp;
		s.exp_err = exp_err;
		steps.push_back(s);
	endtask

	// Locked writes to the lower half leave the reference alone
	task automatic queue_ram_write(input string name, input int word,
		input logic [3:0] sel, input bit locked);
		logic [31:0] dat;
		dat = take_bits(32);
		if (!(locked && word < MON_WORDS / 2)) begin
			ram_ref[word] = merge_bytes(ram_ref[word], dat, sel);
		end
		add_step(name, 1'b1, mon_adr(word, 1'b0), sel, dat, '0, 1'b0);
	endtask

	task automatic queue_ram_read(input string name, input int word, input bit shadow);
		add_step(name, 1'b0, mon_adr(word, shadow), 4'hf, '0, ram_ref[word], 1'b0);
	endtask

	// ----------------------------------------
	// Stimulus table
	// ----------------------------------------
	task automatic build_table();
		int words [6];
		logic [3:0] sel;
		words = '{3, 100, 255, 256, 400, 511};
		// Full-word fill first so no byte stays unknown
		foreach (words[i]) begin
			queue_ram_write("ram_fill", words[i], 4'hf, 1'b0);
		end
		foreach (words[i]) begin
			sel = 4'(take_bits(4));
			queue_ram_write("ram_merge", words[i], sel, 1'b0);
			queue_ram_read("ram_read", words[i], 1'b0);
			queue_ram_read("ram_shadow_read", words[i], 1'b1);
		end
		// Debug write lock
		add_step("lock_on", 1'b1, csr_adr(SYSCTL_PAGE, REG_SYS_CTRL), 4'hf, 32'h1, '0, 1'b0);
		add_step("lock_readback", 1'b0, csr_adr(SYSCTL_PAGE, REG_SYS_CTRL), 4'hf, '0,
			32'h1, 1'b0);
		queue_ram_write("locked_lower_write", 100, 4'hf, 1'b1);
		queue_ram_read("locked_lower_read", 100, 1'b0);
		queue_ram_write("locked_upper_write", 400, 4'hf, 1'b1);
		queue_ram_read("locked_upper_read", 400, 1'b0);
		add_step("lock_off", 1'b1, csr_adr(SYSCTL_PAGE, REG_SYS_CTRL), 4'hf, 32'h0, '0, 1'b0);
		queue_ram_write("unlocked_lower_write", 100, 4'hf, 1'b0);
		queue_ram_read("unlocked_lower_read", 100, 1'b0);
		// GPIO, identity and page decode
		add_step("led_write", 1'b1, csr_adr(SYSCTL_PAGE, REG_GPIO_OUT), 4'hf,
			WB_DAT_W'(LED_PATTERN), '0, 1'b0);
		add_step("led_read", 1'b0, csr_adr(SYSCTL_PAGE, REG_GPIO_OUT), 4'hf, '0,
			WB_DAT_W'(LED_PATTERN), 1'b0);
		add_step("gpio_in_read", 1'b0, csr_adr(SYSCTL_PAGE, REG_GPIO_IN), 4'hf, '0,
			{24'h0, PCB_REVISION, GPIO_PATTERN}, 1'b0);
		add_step("system_id", 1'b0, csr_adr(SYSCTL_PAGE, REG_SYSTEM_ID), 4'hf, '0,
			SYSTEM_ID, 1'b0);
		add_step("other_page", 1'b0, csr_adr(4'd2, REG_SYSTEM_ID), 4'hf, '0, '0, 1'b0);
		// Null trap only once bus errors are on
		add_step("null_read", 1'b0, 32'h0000_0010, 4'hf, '0, '0, 1'b0);
		add_step("buserr_on", 1'b1, csr_adr(SYSCTL_PAGE, REG_SYS_CTRL), 4'hf, 32'h2, '0, 1'b0);
		add_step("null_trap", 1'b0, 32'h0000_0010, 4'hf, '0, '0, 1'b1);
		add_step("unmapped_read", 1'b0, 32'h3000_0040, 4'hf, '0, '0, 1'b0);
		add_step("buserr_off", 1'b1, csr_adr(SYSCTL_PAGE, REG_SYS_CTRL), 4'hf, 32'h0, '0, 1'b0);
		table_ready = 1'b1;
	endtask

	// ----------------------------------------
	// Bus access
	// ----------------------------------------
	// Request held until ack and sampled on the falling edge
	task automatic bus_cycle(input string name, input bit we, input logic [31:0] adr,
		input logic [3:0] sel, input logic [31:0] dat, output logic [31:0] rdat,
		output logic err);
		int waited;
		waited = 0;
		@(posedge sys_clk);
		#1;
		wb_adr_i = adr;
		wb_sel_i = sel;
		wb_dat_i = dat;
		wb_we_i = we;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		@(negedge sys_clk);
		while (wb_ack_o !== 1'b1) begin
			waited++;
			if (waited >= ACCESS_LIMIT) begin
				$display("%s: no bus ack within %0d cycles", name, ACCESS_LIMIT);
				abort_run();
			end
			@(negedge sys_clk);
		end
		rdat = wb_dat_o;
		err = wb_err_o;
		// Strobe dropped in the cycle after ack
		@(posedge sys_clk);
		#1;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
	endtask

	task automatic bus_write(input string name, input logic [31:0] adr,
		input logic [3:0] sel, input logic [31:0] dat, output logic err);
		logic [31:0] unused_rdat;
		bus_cycle(name, 1'b1, adr, sel, dat, unused_rdat, err);
	endtask

	task automatic bus_read(input string name, input logic [31:0] adr,
		output logic [31:0] rdat, output logic err);
		bus_cycle(name, 1'b0, adr, 4'hf, '0, rdat, err);
	endtask

	// Interrupt pulse counters
	always @(negedge sys_clk) begin
		if (gpio_irq_o === 1'b1) begin
			gpio_pulses++;
		end
		if (timer_irq_o === 1'b1) begin
			timer_pulses++;
		end
	end

	// ----------------------------------------
	// Interrupts and hard reset
	// ----------------------------------------
	task automatic check_interrupts();
		logic [31:0] rdat;
		logic err;
		int waited;
		int pulses_before;
		bus_write("gpio_mask", csr_adr(SYSCTL_PAGE, REG_GPIO_MASK), 4'hf, 32'h1, err);
		pulses_before = gpio_pulses;
		gpio_in_i[0] = ~gpio_in_i[0];
		repeat (10) @(posedge sys_clk);
		check_value("gpio_irq_masked", 32'd1, gpio_pulses - pulses_before);
		#1;
		pulses_before = gpio_pulses;
		gpio_in_i[3] = ~gpio_in_i[3];
		repeat (10) @(posedge sys_clk);
		check_value("gpio_irq_unmasked", 32'd0, gpio_pulses - pulses_before);
		// One-shot compare timer
		bus_write("timer_cmp", csr_adr(SYSCTL_PAGE, REG_TIMER_CMP), 4'hf, TIMER_N, err);
		pulses_before = timer_pulses;
		bus_write("timer_start", csr_adr(SYSCTL_PAGE, REG_TIMER_CTRL), 4'hf, 32'h1, err);
		waited = 0;
		while (timer_pulses == pulses_before) begin
			if (waited >= TIMER_N + 20) begin
				$display("Timer interrupt did not appear after enabling the timer");
				abort_run();
			end
			waited++;
			@(posedge sys_clk);
		end
		repeat (10) @(posedge sys_clk);
		check_value("timer_irq_count", 32'd1, timer_pulses - pulses_before);
		bus_read("timer_ctrl", csr_adr(SYSCTL_PAGE, REG_TIMER_CTRL), rdat, err);
		check_value("timer_ctrl_cleared", 32'h0, rdat);
	endtask

	task automatic check_hard_reset();
		logic [31:0] rdat;
		logic err;
		// Lock and bus errors set too and all cleared by the reset
		bus_write("hard_reset", csr_adr(SYSCTL_PAGE, REG_SYS_CTRL), 4'hf, 32'h7, err);
		repeat (RST_STRETCH + 10) @(posedge sys_clk);
		bus_read("gpio_out_after_reset", csr_adr(SYSCTL_PAGE, REG_GPIO_OUT), rdat, err);
		check_value("gpio_out_after_reset", 32'h0, rdat);
		bus_read("sys_ctrl_after_reset", csr_adr(SYSCTL_PAGE, REG_SYS_CTRL), rdat, err);
		check_value("sys_ctrl_after_reset", 32'h0, rdat);
		check_value("led_after_reset", 32'h0, WB_DAT_W'(led_o));
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial begin
		logic [31:0] rdat;
		logic err;
		trigger_reset = 1'b1;
		wb_adr_i = '0;
		wb_dat_i = '0;
		wb_sel_i = '0;
		wb_we_i = 1'b0;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		gpio_in_i = GPIO_PATTERN;
		build_table();
		repeat (16) @(posedge sys_clk);
		#1;
		trigger_reset = 1'b0;
		repeat (RST_STRETCH + 10) @(posedge sys_clk);
		foreach (steps[i]) begin
			if (steps[i].we) begin
				bus_write(steps[i].name, steps[i].adr, steps[i].sel, steps[i].dat, err);
			end else begin
				bus_read(steps[i].name, steps[i].adr, rdat, err);
				check_value(steps[i].name, steps[i].exp, rdat);
			end
			check_value({steps[i].name, "_err"}, 32'(steps[i].exp_err), 32'(err));
		end
		check_value("led_pins", WB_DAT_W'(LED_PATTERN), WB_DAT_W'(led_o));
		check_interrupts();
		check_hard_reset();
		$display("PASS: all tests");
		$finish;
	end

	// Budget of 40 cycles per table row plus reset and timer waits
	initial begin
		wait (table_ready);
		repeat (steps.size() * 40 + 16 + 2 * (RST_STRETCH + 10) + TIMER_N + 20
			+ EXTRA_CYCLES) @(posedge sys_clk);
		$display("Watchdog expired before the tests finished");
		abort_run();
	end

endmodule

`default_nettype wire
